// ==== source/riscv_pkg.sv ====
package riscv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;  // Data and PC word
    typedef logic [2:0]      br_op_t; // Branch operation code

    // Conditional branches reuse funct3
    localparam br_op_t OP_BEQ  = 3'b000;
    localparam br_op_t OP_BNE  = 3'b001;
    localparam br_op_t OP_JAL  = 3'b010; // Free funct3 slots hold the jumps
    localparam br_op_t OP_JALR = 3'b011;
    localparam br_op_t OP_BLT  = 3'b100;
    localparam br_op_t OP_BGE  = 3'b101;
    localparam br_op_t OP_BLTU = 3'b110;
    localparam br_op_t OP_BGEU = 3'b111;

    // Fall-through step, no compressed instructions
    localparam xlen_t INSN_BYTES = 64'd4;

endpackage

// ==== source/bq_pkg.sv ====
package bq_pkg;

    localparam int ROB_ID_W = 6;

    // Tag of an instruction in the reorder buffer
    typedef logic [ROB_ID_W-1:0] rob_id_t;

endpackage

// ==== source/branch_exec_stage.sv ====
`timescale 1ns/1ps

module branch_exec_stage #(
    parameter int BQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          issue_valid_i,
    input  bq_pkg::rob_id_t               issue_rob_id_i,
    input  logic [$clog2(BQ_DEPTH)-1:0]   issue_idx_i,
    input  riscv_pkg::br_op_t             issue_op_i,
    input  riscv_pkg::xlen_t              issue_rs1_i,
    input  riscv_pkg::xlen_t              issue_rs2_i,
    input  riscv_pkg::xlen_t              issue_pc_i,
    input  riscv_pkg::xlen_t              issue_imm_i,
    output logic                          complete_valid_o,
    output bq_pkg::rob_id_t               complete_rob_id_o,
    output logic [$clog2(BQ_DEPTH)-1:0]   ex_idx_o,
    output logic                          ex_taken_o,
    output riscv_pkg::xlen_t              ex_next_pc_o
);

    localparam int IDX_W = $clog2(BQ_DEPTH);

    riscv_pkg::xlen_t diff;
    logic             borrow;
    logic             zero;
    logic             sign;
    logic             lt_signed;
    logic             taken;
    riscv_pkg::xlen_t adder_in;
    riscv_pkg::xlen_t adder_sum;
    riscv_pkg::xlen_t target;
    riscv_pkg::xlen_t next_pc;

    // One subtraction for all compares, borrow set when rs1 < rs2 unsigned
    assign {borrow, diff} = {1'b0, issue_rs1_i} - {1'b0, issue_rs2_i};
    assign zero = (diff == '0);
    assign sign = diff[riscv_pkg::XLEN-1];

    // Signs differ: rs1 negative means less, otherwise no overflow possible
    assign lt_signed = (issue_rs1_i[riscv_pkg::XLEN-1] ^ issue_rs2_i[riscv_pkg::XLEN-1]) ?
                       issue_rs1_i[riscv_pkg::XLEN-1] : sign;

    always_comb begin
        case (issue_op_i)
            riscv_pkg::OP_BEQ:  taken = zero;
            riscv_pkg::OP_BNE:  taken = ~zero;
            riscv_pkg::OP_BLT:  taken = lt_signed;
            riscv_pkg::OP_BGE:  taken = ~lt_signed;
            riscv_pkg::OP_BLTU: taken = borrow;
            riscv_pkg::OP_BGEU: taken = ~borrow;
            default:            taken = 1'b1; // JAL and JALR
        endcase
    end

    // Target base is rs1 only for JALR
    assign adder_in  = (issue_op_i == riscv_pkg::OP_JALR) ? issue_rs1_i : issue_pc_i;
    assign adder_sum = adder_in + issue_imm_i;
    assign target    = (issue_op_i == riscv_pkg::OP_JALR) ? {adder_sum[riscv_pkg::XLEN-1:1], 1'b0}
                                                          : adder_sum;
    assign next_pc   = taken ? target : issue_pc_i + riscv_pkg::INSN_BYTES;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            complete_valid_o <= 1'b0;
        end else begin
            complete_valid_o <= issue_valid_i;
        end
    end

    // Payload follows the valid bit
    always_ff @(posedge clk) begin
        complete_rob_id_o <= issue_rob_id_i;
        ex_idx_o          <= issue_idx_i[IDX_W-1:0];
        ex_taken_o        <= taken;
        ex_next_pc_o      <= next_pc;
    end

endmodule

// ==== source/branch_check_stage.sv ====
`timescale 1ns/1ps

module branch_check_stage #(
    parameter int BQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          ex_valid_i,
    input  logic [$clog2(BQ_DEPTH)-1:0]   ex_idx_i,
    input  logic                          ex_taken_i,
    input  riscv_pkg::xlen_t              ex_next_pc_i,
    output logic [$clog2(BQ_DEPTH)-1:0]   lookup_idx_o,
    input  logic                          lookup_taken_i,
    input  riscv_pkg::xlen_t              lookup_next_pc_i,
    output logic                          res_valid_o,
    output logic [$clog2(BQ_DEPTH)-1:0]   res_idx_o,
    output logic                          res_taken_o,
    output riscv_pkg::xlen_t              res_next_pc_o,
    output logic                          res_mispredict_o
);

    localparam int IDX_W = $clog2(BQ_DEPTH);

    logic mispredict;

    // Stored prediction of the incoming slot, read combinationally
    assign lookup_idx_o = ex_idx_i[IDX_W-1:0];

    // Wrong direction or wrong next PC
    assign mispredict = (ex_taken_i != lookup_taken_i) ||
                        (ex_next_pc_i != lookup_next_pc_i);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        res_idx_o        <= ex_idx_i;
        res_taken_o      <= ex_taken_i;
        res_next_pc_o    <= ex_next_pc_i;
        res_mispredict_o <= mispredict;
    end

endmodule

// ==== source/branch_queue.sv ====
`timescale 1ns/1ps

module branch_queue #(
    parameter int BQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          predict_valid_i,
    input  bq_pkg::rob_id_t               predict_rob_id_i,
    input  logic                          predict_taken_i,
    input  riscv_pkg::xlen_t              predict_next_pc_i,
    output logic                          predict_ready_o,
    output logic [$clog2(BQ_DEPTH)-1:0]   predict_idx_o,
    input  logic [$clog2(BQ_DEPTH)-1:0]   lookup_idx_i,
    output logic                          lookup_taken_o,
    output riscv_pkg::xlen_t              lookup_next_pc_o,
    input  logic                          res_valid_i,
    input  logic [$clog2(BQ_DEPTH)-1:0]   res_idx_i,
    input  logic                          res_taken_i,
    input  riscv_pkg::xlen_t              res_next_pc_i,
    input  logic                          res_mispredict_i,
    input  logic                          retire_valid_i,
    input  bq_pkg::rob_id_t               retire_rob_id_i,
    output logic                          commit_valid_o,
    output logic                          commit_mispredict_o,
    output riscv_pkg::xlen_t              commit_next_pc_o
);

    localparam int IDX_W = $clog2(BQ_DEPTH);

    // Per-slot storage
    bq_pkg::rob_id_t  rob_id_q       [BQ_DEPTH];
    logic             pred_taken_q   [BQ_DEPTH];
    riscv_pkg::xlen_t pred_next_pc_q [BQ_DEPTH];
    logic             resolved_q     [BQ_DEPTH];
    logic             mispredict_q   [BQ_DEPTH];
    riscv_pkg::xlen_t act_next_pc_q  [BQ_DEPTH];

    logic [IDX_W-1:0] tail_q;
    logic [IDX_W-1:0] head_q;
    logic [IDX_W:0]   count_q; // One bit wider so full is exact
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    logic             head_res_hit;

    assign full  = (count_q == (IDX_W+1)'(BQ_DEPTH));
    assign empty = (count_q == '0);

    assign predict_ready_o = ~full;
    assign predict_idx_o   = tail_q;

    assign push = predict_valid_i && ~full;
    // Only a retire of the head branch pops, other retires pass by
    assign pop  = retire_valid_i && ~empty && (rob_id_q[head_q] == retire_rob_id_i);

    assign lookup_taken_o   = pred_taken_q[lookup_idx_i];
    assign lookup_next_pc_o = pred_next_pc_q[lookup_idx_i];

    // Resolution landing on the head in the same cycle as its retire
    assign head_res_hit  = res_valid_i && (res_idx_i == head_q);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tail_q  <= '0;
            head_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= tail_q + 1'b1; // Wraps with the index width
            if (pop)  head_q <= head_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rob_id_q[tail_q]       <= predict_rob_id_i;
            pred_taken_q[tail_q]   <= predict_taken_i;
            pred_next_pc_q[tail_q] <= predict_next_pc_i;
            resolved_q[tail_q]     <= 1'b0;
        end
        // Out of order, any owned slot
        if (res_valid_i) begin
            resolved_q[res_idx_i]    <= 1'b1;
            mispredict_q[res_idx_i]  <= res_mispredict_i;
            act_next_pc_q[res_idx_i] <= res_next_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= pop;
        end
    end

    // Report of the popped head, the flush happens at commit
    always_ff @(posedge clk) begin
        if (pop) begin
            commit_mispredict_o <= head_res_hit ? res_mispredict_i : mispredict_q[head_q];
            commit_next_pc_o    <= head_res_hit ? res_next_pc_i : act_next_pc_q[head_q];
        end
    end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit #(
    parameter int BQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    // Front end insert
    input  logic                          predict_valid_i,
    input  bq_pkg::rob_id_t               predict_rob_id_i,
    input  logic                          predict_taken_i,
    input  riscv_pkg::xlen_t              predict_next_pc_i,
    output logic                          predict_ready_o,
    output logic [$clog2(BQ_DEPTH)-1:0]   predict_idx_o,
    // Issue, never stalled
    input  logic                          issue_valid_i,
    input  bq_pkg::rob_id_t               issue_rob_id_i,
    input  logic [$clog2(BQ_DEPTH)-1:0]   issue_idx_i,
    input  riscv_pkg::br_op_t             issue_op_i,
    input  riscv_pkg::xlen_t              issue_rs1_i,
    input  riscv_pkg::xlen_t              issue_rs2_i,
    input  riscv_pkg::xlen_t              issue_pc_i,
    input  riscv_pkg::xlen_t              issue_imm_i,
    // To and from the ROB
    output logic                          complete_valid_o,
    output bq_pkg::rob_id_t               complete_rob_id_o,
    input  logic                          retire_valid_i,
    input  bq_pkg::rob_id_t               retire_rob_id_i,
    output logic                          commit_valid_o,
    output logic                          commit_mispredict_o,
    output riscv_pkg::xlen_t              commit_next_pc_o
);

    localparam int IDX_W = $clog2(BQ_DEPTH);

    logic [IDX_W-1:0] ex_idx;
    logic             ex_taken;
    riscv_pkg::xlen_t ex_next_pc;
    logic [IDX_W-1:0] lookup_idx;
    logic             lookup_taken;
    riscv_pkg::xlen_t lookup_next_pc;
    logic             res_valid;
    logic [IDX_W-1:0] res_idx;
    logic             res_taken;
    riscv_pkg::xlen_t res_next_pc;
    logic             res_mispredict;

    branch_exec_stage #(
        .BQ_DEPTH (BQ_DEPTH)
    ) i_branch_exec_stage (
        .clk               (clk),
        .rstn              (rstn),
        .issue_valid_i     (issue_valid_i),
        .issue_rob_id_i    (issue_rob_id_i),
        .issue_idx_i       (issue_idx_i),
        .issue_op_i        (issue_op_i),
        .issue_rs1_i       (issue_rs1_i),
        .issue_rs2_i       (issue_rs2_i),
        .issue_pc_i        (issue_pc_i),
        .issue_imm_i       (issue_imm_i),
        .complete_valid_o  (complete_valid_o), // Doubles as the stage-1 valid
        .complete_rob_id_o (complete_rob_id_o),
        .ex_idx_o          (ex_idx),
        .ex_taken_o        (ex_taken),
        .ex_next_pc_o      (ex_next_pc)
    );

    branch_check_stage #(
        .BQ_DEPTH (BQ_DEPTH)
    ) i_branch_check_stage (
        .clk              (clk),
        .rstn             (rstn),
        .ex_valid_i       (complete_valid_o),
        .ex_idx_i         (ex_idx),
        .ex_taken_i       (ex_taken),
        .ex_next_pc_i     (ex_next_pc),
        .lookup_idx_o     (lookup_idx),
        .lookup_taken_i   (lookup_taken),
        .lookup_next_pc_i (lookup_next_pc),
        .res_valid_o      (res_valid),
        .res_idx_o        (res_idx),
        .res_taken_o      (res_taken),
        .res_next_pc_o    (res_next_pc),
        .res_mispredict_o (res_mispredict)
    );

    branch_queue #(
        .BQ_DEPTH (BQ_DEPTH)
    ) i_branch_queue (
        .clk                 (clk),
        .rstn                (rstn),
        .predict_valid_i     (predict_valid_i),
        .predict_rob_id_i    (predict_rob_id_i),
        .predict_taken_i     (predict_taken_i),
        .predict_next_pc_i   (predict_next_pc_i),
        .predict_ready_o     (predict_ready_o),
        .predict_idx_o       (predict_idx_o),
        .lookup_idx_i        (lookup_idx),
        .lookup_taken_o      (lookup_taken),
        .lookup_next_pc_o    (lookup_next_pc),
        .res_valid_i         (res_valid),
        .res_idx_i           (res_idx),
        .res_taken_i         (res_taken),
        .res_next_pc_i       (res_next_pc),
        .res_mispredict_i    (res_mispredict),
        .retire_valid_i      (retire_valid_i),
        .retire_rob_id_i     (retire_rob_id_i),
        .commit_valid_o      (commit_valid_o),
        .commit_mispredict_o (commit_mispredict_o),
        .commit_next_pc_o    (commit_next_pc_o)
    );

endmodule

// ==== sim/branch_unit_asserts.sv ====
`timescale 1ns/1ps

module branch_unit_asserts (
    input logic            clk,
    input logic            rstn,
    input logic            predict_valid_i,
    input logic            predict_ready_i,
    input logic            retire_valid_i,
    input bq_pkg::rob_id_t retire_rob_id_i,
    input bq_pkg::rob_id_t head_rob_id_i,
    input logic            head_pop_i,
    input logic            head_resolved_i,
    input logic            head_res_hit_i,
    input logic            complete_valid_i,
    input logic            commit_valid_i
);

    // Front end holds valid only while there is room
    no_insert_when_full: assert property (@(posedge clk) disable iff (!rstn)
        predict_valid_i |-> predict_ready_i)
        else $error("Insert into a full branch queue");

    // Head resolved in its slot or by the write landing now
    retire_needs_resolved: assert property (@(posedge clk) disable iff (!rstn)
        head_pop_i |-> (head_resolved_i || head_res_hit_i))
        else $error("Retire of a branch that is not resolved");

    commit_after_retire: assert property (@(posedge clk) disable iff (!rstn)
        commit_valid_i |-> $past(retire_valid_i && (retire_rob_id_i == head_rob_id_i)))
        else $error("Commit report without a matching retire");

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> (!complete_valid_i && !commit_valid_i))
        else $error("Valid output high during reset");

endmodule

bind branch_unit branch_unit_asserts i_branch_unit_asserts (
    .clk              (clk),
    .rstn             (rstn),
    .predict_valid_i  (predict_valid_i),
    .predict_ready_i  (predict_ready_o),
    .retire_valid_i   (retire_valid_i),
    .retire_rob_id_i  (retire_rob_id_i),
    .head_rob_id_i    (i_branch_queue.rob_id_q[i_branch_queue.head_q]),
    .head_pop_i       (i_branch_queue.pop),
    .head_resolved_i  (i_branch_queue.resolved_q[i_branch_queue.head_q]),
    .head_res_hit_i   (i_branch_queue.head_res_hit),
    .complete_valid_i (complete_valid_o),
    .commit_valid_i   (commit_valid_o)
);

// ==== sim/tb_branch_unit.sv ====
`timescale 1ns/1ps

module tb_branch_unit;

    localparam int BQ_DEPTH     = 8;
    localparam int IDX_W        = $clog2(BQ_DEPTH);
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FIELDS   = 22;

    logic             clk;
    logic             rstn;
    logic             predict_valid_i;
    bq_pkg::rob_id_t  predict_rob_id_i;
    logic             predict_taken_i;
    riscv_pkg::xlen_t predict_next_pc_i;
    logic             predict_ready_o;
    logic [IDX_W-1:0] predict_idx_o;
    logic             issue_valid_i;
    bq_pkg::rob_id_t  issue_rob_id_i;
    logic [IDX_W-1:0] issue_idx_i;
    riscv_pkg::br_op_t issue_op_i;
    riscv_pkg::xlen_t issue_rs1_i;
    riscv_pkg::xlen_t issue_rs2_i;
    riscv_pkg::xlen_t issue_pc_i;
    riscv_pkg::xlen_t issue_imm_i;
    logic             complete_valid_o;
    bq_pkg::rob_id_t  complete_rob_id_o;
    logic             retire_valid_i;
    bq_pkg::rob_id_t  retire_rob_id_i;
    logic             commit_valid_o;
    logic             commit_mispredict_o;
    riscv_pkg::xlen_t commit_next_pc_o;

    // Expected outputs of the current data line
    logic [2:0]       chk;
    logic             exp_ready;
    logic [IDX_W-1:0] exp_idx;
    logic             exp_complete_valid;
    bq_pkg::rob_id_t  exp_complete_rob_id;
    logic             exp_commit_valid;
    logic             exp_commit_mispredict;
    riscv_pkg::xlen_t exp_commit_next_pc;

    string lines[$];
    bit    loaded;

    branch_unit #(
        .BQ_DEPTH (BQ_DEPTH)
    ) i_branch_unit (
        .clk                 (clk),
        .rstn                (rstn),
        .predict_valid_i     (predict_valid_i),
        .predict_rob_id_i    (predict_rob_id_i),
        .predict_taken_i     (predict_taken_i),
        .predict_next_pc_i   (predict_next_pc_i),
        .predict_ready_o     (predict_ready_o),
        .predict_idx_o       (predict_idx_o),
        .issue_valid_i       (issue_valid_i),
        .issue_rob_id_i      (issue_rob_id_i),
        .issue_idx_i         (issue_idx_i),
        .issue_op_i          (issue_op_i),
        .issue_rs1_i         (issue_rs1_i),
        .issue_rs2_i         (issue_rs2_i),
        .issue_pc_i          (issue_pc_i),
        .issue_imm_i         (issue_imm_i),
        .complete_valid_o    (complete_valid_o),
        .complete_rob_id_o   (complete_rob_id_o),
        .retire_valid_i      (retire_valid_i),
        .retire_rob_id_i     (retire_rob_id_i),
        .commit_valid_o      (commit_valid_o),
        .commit_mispredict_o (commit_mispredict_o),
        .commit_next_pc_o    (commit_next_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic string mismatch(input int num, input string name,
                                       input logic [63:0] got, input logic [63:0] exp);
        return $sformatf("CHECK FAILED at %0d ns: line %0d, %s is %0h, expected %0h",
                         $time, num, name, got, exp);
    endfunction

    // Keeps data lines, drops comments and blank lines
    task automatic read_testdata();
        int    fd;
        string text;
        fd = $fopen("sim/branch_unit_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the data file sim/branch_unit_testdata.txt");
        end
        while ($fgets(text, fd) > 0) begin
            if (text.len() > 1 && text.substr(0, 0) != "#") lines.push_back(text);
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input string text, input int num);
        int fields;
        fields = $sscanf(text,
                         "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         predict_valid_i, predict_rob_id_i, predict_taken_i, predict_next_pc_i,
                         issue_valid_i, issue_rob_id_i, issue_idx_i, issue_op_i,
                         issue_rs1_i, issue_rs2_i, issue_pc_i, issue_imm_i,
                         retire_valid_i, retire_rob_id_i, chk, exp_ready, exp_idx,
                         exp_complete_valid, exp_complete_rob_id,
                         exp_commit_valid, exp_commit_mispredict, exp_commit_next_pc);
        if (fields != NUM_FIELDS) begin
            stop_with_failure($sformatf("Data line %0d has %0d fields instead of %0d",
                                        num, fields, NUM_FIELDS));
        end
    endtask

    // Outputs reflect the state after the previous line was sampled
    task automatic check_line(input int num);
        if (chk[0]) begin
            assert (predict_ready_o === exp_ready) else
                stop_with_failure(mismatch(num, "predict_ready_o",
                                           64'(predict_ready_o), 64'(exp_ready)));
            assert (predict_idx_o === exp_idx) else
                stop_with_failure(mismatch(num, "predict_idx_o",
                                           64'(predict_idx_o), 64'(exp_idx)));
        end
        if (chk[1]) begin
            assert (complete_valid_o === exp_complete_valid) else
                stop_with_failure(mismatch(num, "complete_valid_o",
                                           64'(complete_valid_o), 64'(exp_complete_valid)));
            if (exp_complete_valid) begin
                assert (complete_rob_id_o === exp_complete_rob_id) else
                    stop_with_failure(mismatch(num, "complete_rob_id_o",
                                               64'(complete_rob_id_o), 64'(exp_complete_rob_id)));
            end
        end
        if (chk[2]) begin
            assert (commit_valid_o === exp_commit_valid) else
                stop_with_failure(mismatch(num, "commit_valid_o",
                                           64'(commit_valid_o), 64'(exp_commit_valid)));
            if (exp_commit_valid) begin
                assert (commit_mispredict_o === exp_commit_mispredict) else
                    stop_with_failure(mismatch(num, "commit_mispredict_o",
                                               64'(commit_mispredict_o),
                                               64'(exp_commit_mispredict)));
                assert (commit_next_pc_o === exp_commit_next_pc) else
                    stop_with_failure(mismatch(num, "commit_next_pc_o",
                                               commit_next_pc_o, exp_commit_next_pc));
            end
        end
    endtask

    initial begin
        rstn              = 1'b0;
        predict_valid_i   = 1'b0;
        predict_rob_id_i  = '0;
        predict_taken_i   = 1'b0;
        predict_next_pc_i = '0;
        issue_valid_i     = 1'b0;
        issue_rob_id_i    = '0;
        issue_idx_i       = '0;
        issue_op_i        = '0;
        issue_rs1_i       = '0;
        issue_rs2_i       = '0;
        issue_pc_i        = '0;
        issue_imm_i       = '0;
        retire_valid_i    = 1'b0;
        retire_rob_id_i   = '0;
        chk               = '0;
        read_testdata();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        foreach (lines[n]) begin
            #2;
            if (n == 0) rstn = 1'b1; // Release together with the first line
            apply_line(lines[n], n + 1);
            #(CLK_PERIOD - 3); // Just before the next edge
            check_line(n + 1);
            @(posedge clk);
        end
        $display("No errors");
        $finish;
    end

    // One cycle per data line plus reset, with some slack
    initial begin
        wait (loaded);
        #(CLK_PERIOD * (lines.size() + RESET_CYCLES + 20));
        stop_with_failure("Timeout, the data lines were not all processed in time");
    end

endmodule

// ==== branch_unit.f ====
source/riscv_pkg.sv
source/bq_pkg.sv
source/branch_exec_stage.sv
source/branch_check_stage.sv
source/branch_queue.sv
source/branch_unit.sv
sim/branch_unit_asserts.sv
sim/tb_branch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir \
    -f branch_unit.f --top-module tb_branch_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_branch_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi

// ==== sim/branch_unit_testdata.txt ====
# pv prob ptk ppc | iv irob iidx iop rs1 rs2 ipc imm | rv rrob (inputs, all hex)
# chk(bit0 ready/idx, bit1 complete, bit2 commit) rdy pidx cv crob mv mmis mpc (expected)
1 01 1 140 1 01 0 0 5 5 100 40 0 00 7 1 0 0 00 0 0 0
1 02 1 220 1 02 1 1 ffffffffffffffff 1 200 20 0 00 7 1 1 1 01 0 0 0
1 03 1 330 1 03 2 4 ffffffffffffffff 1 300 30 1 01 7 1 2 1 02 0 0 0
1 04 0 404 1 04 3 5 8000000000000000 7fffffffffffffff 400 40 1 02 7 1 3 1 03 1 0 140
1 05 0 504 1 05 4 6 ffffffffffffffff 1 500 50 1 03 7 1 4 1 04 1 0 220
1 06 1 660 1 06 5 7 8000000000000000 7fffffffffffffff 600 60 1 04 7 1 5 1 05 1 0 330
1 07 1 1000 1 07 6 3 1001 0 700 0 1 05 7 1 6 1 06 1 0 404
1 08 1 880 1 08 7 2 0 0 800 100 1 06 7 1 7 1 07 1 0 504
0 00 0 0 0 00 0 0 0 0 0 0 1 07 7 1 0 1 08 1 0 660
0 00 0 0 0 00 0 0 0 0 0 0 1 08 7 1 0 0 00 1 0 1000
1 0a 0 a04 0 00 0 0 0 0 0 0 0 00 7 1 0 0 00 1 1 900
1 0b 1 b20 0 00 0 0 0 0 0 0 0 00 7 1 1 0 00 0 0 0
1 0c 1 c40 1 0c 2 1 7 7 c00 40 0 00 7 1 2 0 00 0 0 0
0 00 0 0 1 0b 1 7 5 5 b00 20 0 00 7 1 3 1 0c 0 0 0
0 00 0 0 1 0a 0 4 8000000000000000 7fffffffffffffff a00 10 0 00 7 1 3 1 0b 0 0 0
0 00 0 0 0 00 0 0 0 0 0 0 1 3f 7 1 3 1 0a 0 0 0
0 00 0 0 0 00 0 0 0 0 0 0 1 0a 7 1 3 0 00 0 0 0
0 00 0 0 0 00 0 0 0 0 0 0 1 0b 7 1 3 0 00 1 1 a10
0 00 0 0 0 00 0 0 0 0 0 0 1 0c 7 1 3 0 00 1 0 b20
1 10 1 8 1 10 3 0 0 0 0 8 0 00 7 1 3 0 00 1 1 c04
1 11 1 50 1 11 4 2 0 0 40 10 0 00 7 1 4 1 10 0 0 0
1 12 0 0 0 00 0 0 0 0 0 0 0 00 7 1 5 1 11 0 0 0
1 13 0 0 0 00 0 0 0 0 0 0 0 00 7 1 6 0 00 0 0 0
1 14 0 0 0 00 0 0 0 0 0 0 0 00 7 1 7 0 00 0 0 0
1 15 0 0 0 00 0 0 0 0 0 0 0 00 7 1 0 0 00 0 0 0
1 16 0 0 0 00 0 0 0 0 0 0 0 00 7 1 1 0 00 0 0 0
1 17 0 0 0 00 0 0 0 0 0 0 0 00 7 1 2 0 00 0 0 0
0 00 0 0 0 00 0 0 0 0 0 0 1 10 7 0 3 0 00 0 0 0
1 18 0 0 0 00 0 0 0 0 0 0 1 11 7 1 3 0 00 1 0 8
0 00 0 0 0 00 0 0 0 0 0 0 0 00 7 1 4 0 00 1 0 50
